// ==== hdl/axi_word_pkg.sv ====
package axi_word_pkg;

    // Word-side bus geometry
    localparam int ADDR_BITS = 32;
    localparam int DATA_BITS = 64;
    localparam int ID_BITS   = 4;
    localparam int STRB_BITS = DATA_BITS / 8;
    localparam int LEN_BITS  = 8;
    localparam int SIZE_BITS = 3;

    // Byte offset bits inside one word
    localparam int WORD_LOG2 = $clog2(STRB_BITS);

    // Incrementing bursts stay inside a 4 KB page
    localparam int PAGE_LOG2 = 12;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [STRB_BITS-1:0] strb_t;
    typedef logic [ID_BITS-1:0]   id_t;
    typedef logic [LEN_BITS-1:0]  len_t;
    typedef logic [SIZE_BITS-1:0] size_t;

    // Master outputs
    typedef struct packed {
        logic  aw_valid;
        id_t   aw_id;
        addr_t aw_addr;
        size_t aw_size;
        len_t  aw_len;
        logic  w_valid;
        data_t w_data;
        strb_t w_strb;
        logic  ar_valid;
        id_t   ar_id;
        addr_t ar_addr;
        size_t ar_size;
        len_t  ar_len;
        logic  b_ready;
        logic  r_ready;
    } word_req_t;

    // Bridge outputs
    // Every response is OKAY so no response code is carried
    typedef struct packed {
        logic  aw_ready;
        logic  w_ready;
        logic  ar_ready;
        logic  b_valid;
        id_t   b_id;
        logic  r_valid;
        id_t   r_id;
        data_t r_data;
        logic  r_last;
    } word_rsp_t;

endpackage

// ==== hdl/l1_line_pkg.sv ====
package l1_line_pkg;

    // Line geometry
    localparam int LINE_BYTES     = 32;
    localparam int LINE_LOG2      = 5;
    localparam int LINE_BITS      = LINE_BYTES * 8;
    localparam int WORDS_PER_LINE = 4;
    localparam int WORD_IDX_BITS  = $clog2(WORDS_PER_LINE);
    localparam int LINE_COUNT     = 16;
    localparam int LINE_IDX_BITS  = $clog2(LINE_COUNT);

    typedef logic [LINE_BITS-1:0]  line_t;
    typedef logic [LINE_BYTES-1:0] line_strb_t;

    // Bridge to line store
    typedef struct packed {
        logic                ar_valid;
        axi_word_pkg::addr_t ar_addr;
        axi_word_pkg::id_t   ar_id;
        logic                r_ready;
        logic                aw_valid;
        axi_word_pkg::addr_t aw_addr;
        axi_word_pkg::id_t   aw_id;
        logic                w_valid;
        line_t               w_data;
        line_strb_t          w_strb;
        logic                b_ready;
    } line_req_t;

    // Line store to bridge
    typedef struct packed {
        logic  ar_ready;
        logic  r_valid;
        line_t r_data;
        logic  aw_ready;
        logic  w_ready;
        logic  b_valid;
    } line_rsp_t;

    typedef enum logic [3:0] {
        idle,
        write_data_accept,
        read_line_request,
        wait_read_line,
        write_line_request,
        wait_write_confirm,
        wait_write_accept,
        wait_read_accept,
        check_burst
    } bridge_state_t;

endpackage

// ==== hdl/axi_to_l1_bridge.sv ====
`timescale 1ns/1ps

module axi_to_l1_bridge (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  axi_word_pkg::word_req_t i_word_req,
    output axi_word_pkg::word_rsp_t o_word_rsp,
    input  l1_line_pkg::line_rsp_t  i_line_rsp,
    output l1_line_pkg::line_req_t  o_line_req
);

    import axi_word_pkg::*;
    import l1_line_pkg::*;

    // Control state
    bridge_state_t state_q, state_d;
    logic          writing_q, writing_d;
    logic          rmw_q, rmw_d;

    // Request and data holding registers
    id_t   req_id_q, req_id_d;
    addr_t req_addr_q, req_addr_d;
    size_t req_size_q, req_size_d;
    len_t  req_len_q, req_len_d;
    data_t req_wdata_q, req_wdata_d;
    strb_t req_wstrb_q, req_wstrb_d;
    line_t line_q, line_d;
    data_t resp_q, resp_d;

    logic [WORD_IDX_BITS-1:0] word_idx;
    data_t                    byte_mask;
    data_t                    old_word;
    line_t                    merged_line;
    addr_t                    line_addr;
    logic [PAGE_LOG2-1:0]     next_page_off;

    // Word select, byte merge and burst address step
    always_comb begin
        word_idx = req_addr_q[LINE_LOG2-1:WORD_LOG2];
        for (int i = 0; i < STRB_BITS; i++) begin
            byte_mask[8*i +: 8] = {8{req_wstrb_q[i]}};
        end
        old_word    = i_line_rsp.r_data[word_idx*DATA_BITS +: DATA_BITS];
        merged_line = i_line_rsp.r_data;
        merged_line[word_idx*DATA_BITS +: DATA_BITS] = (old_word & ~byte_mask)
                                                     | (req_wdata_q & byte_mask);
        line_addr     = {req_addr_q[ADDR_BITS-1:LINE_LOG2], {LINE_LOG2{1'b0}}};
        next_page_off = req_addr_q[PAGE_LOG2-1:0] + (PAGE_LOG2'(1) << req_size_q);
    end

    always_comb begin
        state_d     = state_q;
        writing_d   = writing_q;
        rmw_d       = rmw_q;
        req_id_d    = req_id_q;
        req_addr_d  = req_addr_q;
        req_size_d  = req_size_q;
        req_len_d   = req_len_q;
        req_wdata_d = req_wdata_q;
        req_wstrb_d = req_wstrb_q;
        line_d      = line_q;
        resp_d      = resp_q;
        o_word_rsp  = '0;
        o_line_req  = '0;

        case (state_q)
            idle: begin
                o_word_rsp.aw_ready = 1'b1;
                o_word_rsp.ar_ready = 1'b1;
                rmw_d = 1'b0;
                // Write takes priority when both arrive together
                if (i_word_req.aw_valid) begin
                    req_id_d   = i_word_req.aw_id;
                    req_addr_d = i_word_req.aw_addr;
                    req_size_d = i_word_req.aw_size;
                    req_len_d  = i_word_req.aw_len;
                    writing_d  = 1'b1;
                    state_d    = write_data_accept;
                end else if (i_word_req.ar_valid) begin
                    req_id_d   = i_word_req.ar_id;
                    req_addr_d = i_word_req.ar_addr;
                    req_size_d = i_word_req.ar_size;
                    req_len_d  = i_word_req.ar_len;
                    writing_d  = 1'b0;
                    state_d    = read_line_request;
                end
            end
            write_data_accept: begin
                o_word_rsp.w_ready = 1'b1;
                if (i_word_req.w_valid) begin
                    req_wdata_d = i_word_req.w_data;
                    req_wstrb_d = i_word_req.w_strb;
                    rmw_d       = 1'b1;
                    state_d     = read_line_request;
                end
            end
            read_line_request: begin
                o_line_req.ar_valid = 1'b1;
                o_line_req.ar_addr  = line_addr;
                o_line_req.ar_id    = req_id_q;
                if (i_line_rsp.ar_ready) begin
                    state_d = wait_read_line;
                end
            end
            wait_read_line: begin
                o_line_req.r_ready = 1'b1;
                if (i_line_rsp.r_valid) begin
                    resp_d = old_word;
                    if (rmw_q) begin
                        line_d  = merged_line;
                        state_d = write_line_request;
                    end else begin
                        state_d = wait_read_accept;
                    end
                end
            end
            write_line_request: begin
                // Address and data go out together as one full line
                o_line_req.aw_valid = 1'b1;
                o_line_req.aw_addr  = line_addr;
                o_line_req.aw_id    = req_id_q;
                o_line_req.w_valid  = 1'b1;
                o_line_req.w_data   = line_q;
                o_line_req.w_strb   = '1;
                if (i_line_rsp.aw_ready && i_line_rsp.w_ready) begin
                    state_d = wait_write_confirm;
                end
            end
            wait_write_confirm: begin
                o_line_req.b_ready = 1'b1;
                if (i_line_rsp.b_valid) begin
                    if (req_len_q == '0) begin
                        state_d = wait_write_accept;
                    end else begin
                        state_d = check_burst;
                    end
                end
            end
            wait_write_accept: begin
                o_word_rsp.b_valid = 1'b1;
                o_word_rsp.b_id    = req_id_q;
                if (i_word_req.b_ready) begin
                    state_d = idle;
                end
            end
            wait_read_accept: begin
                o_word_rsp.r_valid = 1'b1;
                o_word_rsp.r_id    = req_id_q;
                o_word_rsp.r_data  = resp_q;
                o_word_rsp.r_last  = (req_len_q == '0);
                if (i_word_req.r_ready) begin
                    state_d = check_burst;
                end
            end
            check_burst: begin
                if (req_len_q == '0) begin
                    state_d = idle;
                end else begin
                    req_len_d  = req_len_q - 1'b1;
                    req_addr_d = {req_addr_q[ADDR_BITS-1:PAGE_LOG2], next_page_off};
                    rmw_d      = 1'b0;
                    state_d    = writing_q ? write_data_accept : read_line_request;
                end
            end
            default: begin
                state_d = idle;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q   <= idle;
            writing_q <= 1'b0;
            rmw_q     <= 1'b0;
        end else begin
            state_q   <= state_d;
            writing_q <= writing_d;
            rmw_q     <= rmw_d;
        end
    end

    always_ff @(posedge i_clk) begin
        req_id_q    <= req_id_d;
        req_addr_q  <= req_addr_d;
        req_size_q  <= req_size_d;
        req_len_q   <= req_len_d;
        req_wdata_q <= req_wdata_d;
        req_wstrb_q <= req_wstrb_d;
        line_q      <= line_d;
        resp_q      <= resp_d;
    end

endmodule

// ==== hdl/l1_line_store.sv ====
`timescale 1ns/1ps

module l1_line_store (
    input  logic                   i_clk,
    input  logic                   i_nrst,
    input  l1_line_pkg::line_req_t i_line_req,
    output l1_line_pkg::line_rsp_t o_line_rsp
);

    import l1_line_pkg::*;

    typedef enum logic [1:0] {
        store_idle,
        store_read_rsp,
        store_write_rsp
    } store_state_t;

    store_state_t state_q;
    line_t        mem [LINE_COUNT];
    line_t        rd_line_q;

    logic                     is_idle;
    logic                     write_fire;
    logic                     read_fire;
    logic [LINE_IDX_BITS-1:0] wr_idx;
    logic [LINE_IDX_BITS-1:0] rd_idx;

    assign is_idle    = (state_q == store_idle);
    assign write_fire = is_idle && i_line_req.aw_valid && i_line_req.w_valid;
    // A presented write blocks the read handshake in the same cycle
    assign read_fire  = is_idle && i_line_req.ar_valid && !write_fire;

    assign wr_idx = i_line_req.aw_addr[LINE_LOG2 +: LINE_IDX_BITS];
    assign rd_idx = i_line_req.ar_addr[LINE_LOG2 +: LINE_IDX_BITS];

    assign o_line_rsp.aw_ready = is_idle;
    assign o_line_rsp.w_ready  = is_idle;
    assign o_line_rsp.ar_ready = is_idle && !(i_line_req.aw_valid && i_line_req.w_valid);
    assign o_line_rsp.r_valid  = (state_q == store_read_rsp);
    assign o_line_rsp.r_data   = rd_line_q;
    assign o_line_rsp.b_valid  = (state_q == store_write_rsp);

    // One request at a time with each response held until taken
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= store_idle;
        end else begin
            case (state_q)
                store_idle: begin
                    if (write_fire) begin
                        state_q <= store_write_rsp;
                    end else if (read_fire) begin
                        state_q <= store_read_rsp;
                    end
                end
                store_read_rsp: begin
                    if (i_line_req.r_ready) begin
                        state_q <= store_idle;
                    end
                end
                store_write_rsp: begin
                    if (i_line_req.b_ready) begin
                        state_q <= store_idle;
                    end
                end
                default: begin
                    state_q <= store_idle;
                end
            endcase
        end
    end

    // Store contents start at zero; writes honor the byte strobes
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < LINE_COUNT; i++) begin
                mem[i] <= '0;
            end
        end else if (write_fire) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (i_line_req.w_strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= i_line_req.w_data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (read_fire) begin
            rd_line_q <= mem[rd_idx];
        end
    end

endmodule

// ==== hdl/l1_bridge_top.sv ====
`timescale 1ns/1ps

module l1_bridge_top (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  axi_word_pkg::word_req_t i_word_req,
    output axi_word_pkg::word_rsp_t o_word_rsp
);

    import l1_line_pkg::*;

    // Line-side channels between bridge and store
    line_req_t line_req;
    line_rsp_t line_rsp;

    axi_to_l1_bridge axi_to_l1_bridge_i (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_word_req (i_word_req),
        .o_word_rsp (o_word_rsp),
        .i_line_rsp (line_rsp),
        .o_line_req (line_req)
    );

    l1_line_store l1_line_store_i (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_line_req (line_req),
        .o_line_rsp (line_rsp)
    );

endmodule

// ==== dv/l1_bridge_props.sv ====
`timescale 1ns/1ps

module l1_bridge_props (
    input logic                    i_clk,
    input logic                    i_nrst,
    input axi_word_pkg::word_req_t i_word_req,
    input axi_word_pkg::word_rsp_t i_word_rsp,
    input l1_line_pkg::line_rsp_t  i_line_rsp,
    input l1_line_pkg::line_req_t  i_line_req
);

    import l1_line_pkg::*;

    int unsigned fail_count = 0;

    // Word-side responses hold until the master takes them
    r_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_word_rsp.r_valid && !i_word_req.r_ready |=>
            i_word_rsp.r_valid && $stable(i_word_rsp.r_data)
            && $stable(i_word_rsp.r_last) && $stable(i_word_rsp.r_id))
    else begin
        $error("r channel changed before its handshake");
        fail_count++;
    end

    b_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_word_rsp.b_valid && !i_word_req.b_ready |=>
            i_word_rsp.b_valid && $stable(i_word_rsp.b_id))
    else begin
        $error("b channel changed before its handshake");
        fail_count++;
    end

    // Line side
    ar_aligned: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_line_req.ar_valid |-> i_line_req.ar_addr[LINE_LOG2-1:0] == '0)
    else begin
        $error("line read address not line aligned");
        fail_count++;
    end

    aw_aligned: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_line_req.aw_valid |-> i_line_req.aw_addr[LINE_LOG2-1:0] == '0)
    else begin
        $error("line write address not line aligned");
        fail_count++;
    end

    full_strobe: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_line_req.w_valid |-> &i_line_req.w_strb)
    else begin
        $error("line write without all strobes set");
        fail_count++;
    end

    no_ar_pending: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_line_req.ar_valid |-> !i_line_rsp.r_valid && !i_line_rsp.b_valid)
    else begin
        $error("line read issued while a line response is pending");
        fail_count++;
    end

    quiet_after_reset: assert property (@(posedge i_clk)
        $rose(i_nrst) |-> !(i_word_rsp.r_valid || i_word_rsp.b_valid
            || i_word_rsp.w_ready || i_line_req.ar_valid || i_line_req.aw_valid
            || i_line_req.w_valid || i_line_rsp.r_valid || i_line_rsp.b_valid))
    else begin
        $error("valid or w_ready high right after reset release");
        fail_count++;
    end

endmodule

// ==== dv/tb_l1_bridge.sv ====
`timescale 1ns/1ps

module tb_l1_bridge;

    import axi_word_pkg::*;
    import l1_line_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int MODEL_BYTES    = 512;

    logic      clk;
    logic      nrst;
    word_req_t word_req;
    word_rsp_t word_rsp;

    logic [31:0] lfsr = 32'hb76b6609;
    logic [7:0]  model_mem [MODEL_BYTES];
    logic        gaps;

    l1_bridge_top l1_bridge_top_i (
        .i_clk      (clk),
        .i_nrst     (nrst),
        .i_word_req (word_req),
        .o_word_rsp (word_rsp)
    );

    bind axi_to_l1_bridge l1_bridge_props l1_bridge_props_i (
        .i_clk      (i_clk),
        .i_nrst     (i_nrst),
        .i_word_req (i_word_req),
        .i_word_rsp (o_word_rsp),
        .i_line_rsp (i_line_rsp),
        .i_line_req (o_line_req)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin
        if (l1_bridge_top_i.axi_to_l1_bridge_i.l1_bridge_props_i.fail_count != 0) begin
            fail_run("a protocol assertion in l1_bridge_props failed");
        end
    end

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Ready is always high unless back-pressure gaps are on
    function automatic logic ready_draw();
        return gaps ? lfsr_bit() : 1'b1;
    endfunction

    function automatic data_t model_word(addr_t addr);
        data_t w;
        for (int i = 0; i < STRB_BITS; i++) begin
            w[8*i +: 8] = model_mem[(addr + i) % MODEL_BYTES];
        end
        return w;
    endfunction

    task automatic fail_run(string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
        assert (actual === expected) else begin
            fail_run($sformatf("error: time %0t ns %s expected %h actual %h",
                               $time, name, expected, actual));
        end
    endtask

    task automatic bump_wait(inout int waited, input string what);
        waited++;
        if (waited > TIMEOUT_CYCLES) begin
            fail_run({"timeout waiting for ", what});
        end
    endtask

    // Entered and left on a falling edge
    task automatic write_burst(addr_t addr, len_t len, id_t id);
        int    waited;
        addr_t beat_addr;
        data_t data;
        strb_t strb;
        word_req.aw_valid = 1'b1;
        word_req.aw_id    = id;
        word_req.aw_addr  = addr;
        word_req.aw_size  = 3'd3;
        word_req.aw_len   = len;
        waited = 0;
        while (!word_rsp.aw_ready) begin
            @(negedge clk);
            bump_wait(waited, "aw_ready");
        end
        @(negedge clk);
        word_req.aw_valid = 1'b0;
        beat_addr = addr;
        for (int beat = 0; beat <= len; beat++) begin
            data = rand_bits(64);
            strb = strb_t'(rand_bits(8));
            word_req.w_valid = 1'b1;
            word_req.w_data  = data;
            word_req.w_strb  = strb;
            waited = 0;
            while (!word_rsp.w_ready) begin
                check_value("b_valid", word_rsp.b_valid, 0);
                @(negedge clk);
                bump_wait(waited, "w_ready");
            end
            for (int i = 0; i < STRB_BITS; i++) begin
                if (strb[i]) begin
                    model_mem[(beat_addr + i) % MODEL_BYTES] = data[8*i +: 8];
                end
            end
            beat_addr = beat_addr + 8;
            @(negedge clk);
            word_req.w_valid = 1'b0;
        end
        waited = 0;
        word_req.b_ready = ready_draw();
        while (!(word_rsp.b_valid && word_req.b_ready)) begin
            @(negedge clk);
            word_req.b_ready = ready_draw();
            bump_wait(waited, "b_valid");
        end
        check_value("b_id", word_rsp.b_id, id);
        @(negedge clk);
        word_req.b_ready = 1'b0;
        check_value("b_valid", word_rsp.b_valid, 0);
    endtask

    task automatic read_burst(addr_t addr, len_t len, id_t id);
        int    waited;
        int    beat;
        addr_t beat_addr;
        word_req.ar_valid = 1'b1;
        word_req.ar_id    = id;
        word_req.ar_addr  = addr;
        word_req.ar_size  = 3'd3;
        word_req.ar_len   = len;
        waited = 0;
        while (!word_rsp.ar_ready) begin
            @(negedge clk);
            bump_wait(waited, "ar_ready");
        end
        @(negedge clk);
        word_req.ar_valid = 1'b0;
        beat      = 0;
        beat_addr = addr;
        waited    = 0;
        while (beat <= len) begin
            word_req.r_ready = ready_draw();
            if (word_rsp.r_valid && word_req.r_ready) begin
                check_value("r_data", word_rsp.r_data, model_word(beat_addr));
                check_value("r_id", word_rsp.r_id, id);
                check_value("r_last", word_rsp.r_last, beat == len);
                beat++;
                beat_addr = beat_addr + 8;
            end
            check_value("b_valid", word_rsp.b_valid, 0);
            @(negedge clk);
            bump_wait(waited, "r_valid");
        end
        word_req.r_ready = 1'b0;
    endtask

    initial begin
        addr_t addr;
        id_t   id;
        len_t  len;
        word_req = '0;
        nrst     = 1'b0;
        gaps     = 1'b0;
        for (int i = 0; i < MODEL_BYTES; i++) begin
            model_mem[i] = 8'h00;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);
        check_value("w_ready", word_rsp.w_ready, 0);
        check_value("r_valid", word_rsp.r_valid, 0);
        check_value("b_valid", word_rsp.b_valid, 0);
        check_value("aw_ready", word_rsp.aw_ready, 1);
        check_value("ar_ready", word_rsp.ar_ready, 1);

        read_burst(addr_t'(rand_bits(6) << 3), 0, id_t'(rand_bits(4)));

        // Partial write followed by reads of the word and its neighbor in the same line
        addr = addr_t'(rand_bits(6) << 3);
        write_burst(addr, 0, id_t'(rand_bits(4)));
        read_burst(addr, 0, id_t'(rand_bits(4)));
        read_burst(addr ^ 32'd8, 0, id_t'(rand_bits(4)));

        // Four beats starting late in a line
        addr = addr_t'((rand_bits(4) % 15) * 32 + (2 + rand_bits(1)) * 8);
        write_burst(addr, 3, id_t'(rand_bits(4)));
        read_burst(addr, 3, id_t'(rand_bits(4)));

        gaps = 1'b1;
        repeat (6) begin
            len  = len_t'(rand_bits(2));
            addr = addr_t'(rand_bits(6) << 3);
            if (addr > 480) begin
                addr = 480;
            end
            write_burst(addr, len, id_t'(rand_bits(4)));
            read_burst(addr, len, id_t'(rand_bits(4)));
        end
        gaps = 1'b0;

        // Write and read of one word raised together
        addr = addr_t'(rand_bits(6) << 3);
        id   = id_t'(rand_bits(4));
        word_req.ar_valid = 1'b1;
        word_req.ar_id    = id + 1'b1;
        word_req.ar_addr  = addr;
        word_req.ar_size  = 3'd3;
        word_req.ar_len   = '0;
        write_burst(addr, 0, id);
        read_burst(addr, 0, id + 1'b1);

        repeat (2) @(negedge clk);
        if (l1_bridge_top_i.axi_to_l1_bridge_i.l1_bridge_props_i.fail_count != 0) begin
            fail_run("a protocol assertion in l1_bridge_props failed");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== flist.f ====
hdl/axi_word_pkg.sv
hdl/l1_line_pkg.sv
hdl/axi_to_l1_bridge.sv
hdl/l1_line_store.sv
hdl/l1_bridge_top.sv
dv/l1_bridge_props.sv
dv/tb_l1_bridge.sv
